//--- dm9000a_bus_cycle.sv
module dm9000a_bus_cycle
   import dm9000a_reg_pkg::*;
   import enet_ctrl_pkg::*;
(
   input  logic        clk_enet,
   input  logic        reset,
   input  logic        cmd_start,
   input  bus_kind_e   cmd_kind,
   input  logic [7:0]  cmd_index,
   input  logic [15:0] cmd_data,
   input  logic        fetch,
   input  logic        pkt_done,
   output logic        bus_busy,
   output dm_word_u    rd_word,
   output logic        word_valid,
   output word_tag_e   word_tag,
   output logic        enet_cmd,
   output logic        enet_wr_n,
   output logic        enet_rd_n,
   inout  wire  [15:0] enet_data
);

   bus_state_e  state;
   bus_state_e  state_d;
   bus_kind_e   kind;
   logic [15:0] data_out;

   assign bus_busy  = (state != bs_idle);

   // Only drive the bus while writing.
   assign enet_data = !enet_wr_n ? data_out : 16'hzzzz;

   always_comb begin
      state_d = state;
      case (state)
         bs_idle:     if (cmd_start) state_d = bs_index;
         bs_index:    state_d = bs_spin;
         bs_spin: begin
            case (kind)
               bus_write:    state_d = bs_write;
               bus_prefetch: state_d = bs_pf_dummy;
               default:      state_d = bs_rd0;
            endcase
         end
         bs_write:    state_d = bs_idle;
         bs_rd0:      state_d = bs_rd1;
         bs_rd1:      state_d = (kind == bus_packet) ? bs_pkt_gap : bs_idle;
         // The chip needs two idle cycles between the prefetch reads.
         bs_pf_dummy: state_d = bs_pf_spin0;
         bs_pf_spin0: state_d = bs_pf_spin1;
         bs_pf_spin1: state_d = bs_rd0;
         // Status and length follow at once. Body words wait for fetch.
         bs_pkt_gap: begin
            if (word_tag == tag_status)
               state_d = bs_rd0;
            else if (pkt_done)
               state_d = bs_idle;
            else if (fetch)
               state_d = bs_rd0;
         end
         default:     state_d = bs_idle;
      endcase
   end

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         state      <= bs_idle;
         word_valid <= 1'b0;
         word_tag   <= tag_status;
         enet_cmd   <= bus_type_data;
         enet_wr_n  <= 1'b1;
         enet_rd_n  <= 1'b1;
      end else begin
         state      <= state_d;
         word_valid <= (state == bs_rd1) && (kind == bus_packet);
         if (state == bs_idle && cmd_start)
            word_tag <= tag_status;
         else if (state == bs_pkt_gap && state_d == bs_rd0)
            word_tag <= (word_tag == tag_status) ? tag_length : tag_body;
         // Pins follow the next state so they change cleanly on the edge.
         enet_cmd  <= (state_d == bs_index) ? bus_type_index : bus_type_data;
         enet_wr_n <= !(state_d == bs_index || state_d == bs_write);
         enet_rd_n <= !(state_d == bs_rd0 || state_d == bs_rd1 ||
                        state_d == bs_pf_dummy);
      end
   end

   always_ff @(posedge clk_enet) begin
      if (state == bs_idle && cmd_start) begin
         kind     <= cmd_kind;
         data_out <= {8'h00, cmd_index};
      end
      // Sequencer holds cmd_data until the bus is free again.
      if (state == bs_spin)
         data_out <= cmd_data;
      // Sampled while the read strobe is still low.
      if (state == bs_rd1)
         rd_word.raw <= enet_data;
   end

endmodule

//--- dm9000a_chip_model.sv
module dm9000a_chip_model
   import dm9000a_reg_pkg::*;
(
   input  logic        clk_enet,
   input  logic        enet_cmd,
   input  logic        enet_wr_n,
   input  logic        enet_rd_n,
   inout  wire  [15:0] enet_data,
   output logic        enet_int,
   input  logic        link_up,
   input  logic [7:0]  irq_set,
   input  logic        push_valid,
   input  logic [15:0] push_word,
   output logic        log_valid,
   output logic [7:0]  log_index,
   output logic [7:0]  log_value
);

   timeunit 1ns;
   timeprecision 100ps;

   // Receive memory, as the chip presents it word by word.
   logic [15:0] rx_mem [0:1023];
   int          head = 0;
   int          tail = 0;
   logic [7:0]  index = 8'h00;
   logic [7:0]  isr = 8'h00;
   logic [7:0]  imr = 8'h00;
   logic        rd_n_q = 1'b1;
   logic        data_wr;
   dm_word_u    rd_value;

   assign data_wr   = !enet_wr_n && enet_cmd;
   assign enet_int  = (isr & imr & isr_all) != 8'h00;
   assign enet_data = (!enet_rd_n && enet_cmd) ? rd_value.raw : 16'hzzzz;

   always_comb begin
      rd_value.raw = 16'h0000;
      if (index == reg_isr) begin
         rd_value.raw = {8'h00, isr};
      end else if (index == reg_nsr) begin
         rd_value.raw = {8'h00, link_up ? nsr_link : 8'h00};
      end else if (index == reg_mrcmdx || index == reg_mrcmd) begin
         // An empty receive memory reads as not ready.
         rd_value.pkt.status = 8'h00;
         rd_value.pkt.ready  = 8'h00;
         if (head != tail)
            rd_value.raw = rx_mem[head];
      end
   end

   always @(posedge clk_enet) begin
      log_valid <= data_wr;
      rd_n_q    <= enet_rd_n;
      if (!enet_wr_n && !enet_cmd)
         index <= enet_data[7:0];
      if (data_wr) begin
         log_index <= index;
         log_value <= enet_data[7:0];
      end
      if (data_wr && index == reg_imr)
         imr <= enet_data[7:0];
      // Status bits clear where a 1 is written.
      if (data_wr && index == reg_isr)
         isr <= (isr & ~enet_data[7:0]) | irq_set;
      else
         isr <= isr | irq_set;
      // Each finished MRCMD read moves on to the next word.
      if (!rd_n_q && enet_rd_n && index == reg_mrcmd && head != tail)
         head <= head + 1;
      if (push_valid) begin
         rx_mem[tail] <= push_word;
         tail         <= tail + 1;
      end
   end

endmodule

//--- dm9000a_cmd_sequencer.sv
module dm9000a_cmd_sequencer
   import dm9000a_reg_pkg::*;
   import enet_ctrl_pkg::*;
#(
   parameter logic [47:0]           mac_address       = 48'h0102_0304_0506,
   parameter logic [63:0]           multicast_address = 64'h0,
   parameter logic                  promiscuous_en    = 1'b1,
   parameter logic                  broadcast_en      = 1'b1,
   parameter logic [spin_width-1:0] phy_spin_cycles   = 20'd500000,
   parameter logic [spin_width-1:0] reset_spin_cycles = 20'd250
) (
   input  logic        clk_enet,
   input  logic        reset,
   input  logic        enet_int,
   input  logic        bus_busy,
   input  dm_word_u    rd_word,
   input  logic        pkt_done,
   output logic        cmd_start,
   output bus_kind_e   cmd_kind,
   output logic [7:0]  cmd_index,
   output logic [15:0] cmd_data,
   output logic        link_status
);

   localparam logic [4:0] init_last = 5'd18;

   cmd_state_e            state;
   logic [spin_width-1:0] spin_cnt;
   logic [4:0]            step;
   logic [7:0]            irq_flags;
   logic [7:0]            init_index;
   logic [7:0]            init_value;
   logic                  bus_free;

   // The bus only raises busy in the cycle after a start pulse.
   assign bus_free = !bus_busy && !cmd_start;

   ////////////////////////////////////////
   // Power-up register table
   ////////////////////////////////////////

   always_comb begin
      init_index = reg_imr;
      init_value = imr_enable_bits;
      case (step) inside
         5'd0: begin
            // Clearing GPR bit 0 powers up the PHY.
            init_index = reg_gpr;
            init_value = 8'h00;
         end
         5'd1: begin
            init_index = reg_nsr;
            init_value = nsr_clear_bits;
         end
         5'd2: begin
            init_index = reg_isr;
            init_value = isr_all;
         end
         [5'd3:5'd8]: begin
            init_index = reg_par0 + 8'(step - 5'd3);
            init_value = mac_address[8 * (step - 5'd3) +: 8];
         end
         [5'd9:5'd16]: begin
            init_index = reg_mar0 + 8'(step - 5'd9);
            init_value = multicast_address[8 * (step - 5'd9) +: 8];
            // Top hash bit of MAR7 accepts broadcast frames.
            if (step == 5'd16 && broadcast_en)
               init_value[7] = 1'b1;
         end
         5'd17: begin
            init_index = reg_rxcr;
            init_value = rxcr_rxen | (promiscuous_en ? rxcr_prmsc : 8'h00);
         end
         default: begin
            init_index = reg_imr;
            init_value = imr_enable_bits;
         end
      endcase
   end

   task automatic issue(input bus_kind_e kind, input logic [7:0] index,
                        input logic [15:0] data);
      cmd_start <= 1'b1;
      cmd_kind  <= kind;
      cmd_index <= index;
      cmd_data  <= data;
   endtask

   ////////////////////////////////////////
   // Command FSM
   ////////////////////////////////////////

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         state       <= cs_phy_wait;
         spin_cnt    <= phy_spin_cycles;
         step        <= 5'd0;
         irq_flags   <= 8'h00;
         link_status <= 1'b0;
         cmd_start   <= 1'b0;
      end else begin
         cmd_start <= 1'b0;
         case (state)
            cs_phy_wait, cs_reset_wait: begin
               if (spin_cnt != '0)
                  spin_cnt <= spin_cnt - 1'b1;
               else
                  state <= (state == cs_phy_wait) ? cs_reset : cs_init;
            end
            cs_reset: begin
               if (bus_free) begin
                  issue(bus_write, reg_ncr, {8'h00, ncr_rst});
                  spin_cnt <= reset_spin_cycles;
                  step     <= 5'd0;
                  state    <= cs_reset_wait;
               end
            end
            cs_init: begin
               if (bus_free) begin
                  issue(bus_write, init_index, {8'h00, init_value});
                  if (step == init_last)
                     state <= cs_idle;
                  else
                     step <= step + 1'b1;
               end
            end
            // Interrupt entry. Mask everything but pointer wrap first.
            cs_idle: begin
               if (enet_int && bus_free) begin
                  issue(bus_write, reg_imr, {8'h00, imr_par});
                  state <= cs_irq_read;
               end
            end
            cs_irq_read: begin
               if (bus_free) begin
                  issue(bus_read, reg_isr, 16'h0000);
                  state <= cs_irq_clear;
               end
            end
            cs_irq_clear: begin
               if (bus_free) begin
                  irq_flags <= rd_word.raw[7:0];
                  issue(bus_write, reg_isr, {8'h00, isr_all});
                  state <= cs_dispatch;
               end
            end
            // Serve one pending flag per pass, then unmask.
            cs_dispatch: begin
               if (bus_free) begin
                  if ((irq_flags & isr_lnkchg) != 8'h00) begin
                     irq_flags <= irq_flags & ~isr_lnkchg;
                     issue(bus_read, reg_nsr, 16'h0000);
                     state <= cs_link_update;
                  end else if ((irq_flags & isr_pr) != 8'h00) begin
                     irq_flags <= irq_flags & ~isr_pr;
                     issue(bus_prefetch, reg_mrcmdx, 16'h0000);
                     state <= cs_rx_check;
                  end else begin
                     issue(bus_write, reg_imr, {8'h00, imr_enable_bits});
                     state <= cs_idle;
                  end
               end
            end
            cs_link_update: begin
               if (bus_free) begin
                  link_status <= (rd_word.raw[7:0] & nsr_link) != 8'h00;
                  state       <= cs_dispatch;
               end
            end
            // A ready byte of 1 means a packet waits in the chip.
            cs_rx_check: begin
               if (bus_free) begin
                  if (rd_word.pkt.ready == 8'h01) begin
                     issue(bus_packet, reg_mrcmd, 16'h0000);
                     state <= cs_rx_packet;
                  end else begin
                     state <= cs_dispatch;
                  end
               end
            end
            cs_rx_packet: begin
               if (pkt_done)
                  state <= cs_rx_prefetch;
            end
            cs_rx_prefetch: begin
               if (bus_free) begin
                  issue(bus_prefetch, reg_mrcmdx, 16'h0000);
                  state <= cs_rx_check;
               end
            end
            default: state <= cs_idle;
         endcase
      end
   end

endmodule

//--- dm9000a_controller.sv
module dm9000a_controller
   import dm9000a_reg_pkg::*;
   import enet_ctrl_pkg::*;
#(
   parameter logic [47:0]           mac_address       = 48'h0102_0304_0506,
   parameter logic [63:0]           multicast_address = 64'h0,
   parameter logic                  promiscuous_en    = 1'b1,
   parameter logic                  broadcast_en      = 1'b1,
   parameter logic [spin_width-1:0] phy_spin_cycles   = 20'd500000,
   parameter logic [spin_width-1:0] reset_spin_cycles = 20'd250
) (
   input  logic        clk_enet,
   input  logic        reset,
   input  logic        enet_int,
   input  logic        halt,
   output logic        enet_rst_n,
   output logic        enet_cs_n,
   output logic        enet_cmd,
   output logic        enet_wr_n,
   output logic        enet_rd_n,
   inout  wire  [15:0] enet_data,
   output logic        link_status,
   output logic        rx_valid,
   output logic [15:0] rx_data
);

   logic        cmd_start;
   bus_kind_e   cmd_kind;
   logic [7:0]  cmd_index;
   logic [15:0] cmd_data;
   logic        bus_busy;
   dm_word_u    rd_word;
   logic        word_valid;
   word_tag_e   word_tag;
   logic        fetch;
   logic        pkt_done;

   assign enet_rst_n = ~reset;
   assign enet_cs_n  = 1'b0;

   dm9000a_cmd_sequencer #(
      .mac_address       (mac_address),
      .multicast_address (multicast_address),
      .promiscuous_en    (promiscuous_en),
      .broadcast_en      (broadcast_en),
      .phy_spin_cycles   (phy_spin_cycles),
      .reset_spin_cycles (reset_spin_cycles)
   ) u_sequencer (
      .clk_enet    (clk_enet),
      .reset       (reset),
      .enet_int    (enet_int),
      .bus_busy    (bus_busy),
      .rd_word     (rd_word),
      .pkt_done    (pkt_done),
      .cmd_start   (cmd_start),
      .cmd_kind    (cmd_kind),
      .cmd_index   (cmd_index),
      .cmd_data    (cmd_data),
      .link_status (link_status)
   );

   dm9000a_bus_cycle u_bus_cycle (
      .clk_enet   (clk_enet),
      .reset      (reset),
      .cmd_start  (cmd_start),
      .cmd_kind   (cmd_kind),
      .cmd_index  (cmd_index),
      .cmd_data   (cmd_data),
      .fetch      (fetch),
      .pkt_done   (pkt_done),
      .bus_busy   (bus_busy),
      .rd_word    (rd_word),
      .word_valid (word_valid),
      .word_tag   (word_tag),
      .enet_cmd   (enet_cmd),
      .enet_wr_n  (enet_wr_n),
      .enet_rd_n  (enet_rd_n),
      .enet_data  (enet_data)
   );

   dm9000a_rx_frame u_rx_frame (
      .clk_enet   (clk_enet),
      .reset      (reset),
      .halt       (halt),
      .word_valid (word_valid),
      .word_tag   (word_tag),
      .rd_word    (rd_word),
      .fetch      (fetch),
      .pkt_done   (pkt_done),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data)
   );

endmodule

//--- dm9000a_controller_chk.sv
module dm9000a_controller_chk (
   input logic clk_enet,
   input logic reset,
   input logic enet_wr_n,
   input logic enet_rd_n,
   input logic rx_valid
);

   timeunit 1ns;
   timeprecision 100ps;

   // The chip must never see both strobes at once.
   strobes_exclusive: assert property (@(posedge clk_enet) disable iff (reset)
      !(!enet_wr_n && !enet_rd_n))
      else $error("enet_wr_n and enet_rd_n are both low");

   strobes_idle_after_reset: assert property (@(posedge clk_enet)
      reset |=> (enet_wr_n && enet_rd_n))
      else $error("bus strobes not idle after reset");

   // Each output word needs a read strobe of its own.
   rx_valid_single: assert property (@(posedge clk_enet) disable iff (reset)
      rx_valid |=> (!rx_valid || $rose(enet_rd_n)))
      else $error("rx_valid held without a new read");

endmodule

bind dm9000a_controller dm9000a_controller_chk u_chk (
   .clk_enet  (clk_enet),
   .reset     (reset),
   .enet_wr_n (enet_wr_n),
   .enet_rd_n (enet_rd_n),
   .rx_valid  (rx_valid)
);

//--- dm9000a_reg_pkg.sv
package dm9000a_reg_pkg;

   ////////////////////////////////////////
   // Register indices
   ////////////////////////////////////////

   localparam logic [7:0] reg_ncr    = 8'h00;
   localparam logic [7:0] reg_nsr    = 8'h01;
   localparam logic [7:0] reg_rxcr   = 8'h05;
   // PAR0..PAR5 and MAR0..MAR7 are consecutive from these bases.
   localparam logic [7:0] reg_par0   = 8'h10;
   localparam logic [7:0] reg_mar0   = 8'h16;
   localparam logic [7:0] reg_gpr    = 8'h1f;
   // Memory read with prefetch and no address increment.
   localparam logic [7:0] reg_mrcmdx = 8'hf0;
   // Memory read with address increment.
   localparam logic [7:0] reg_mrcmd  = 8'hf2;
   localparam logic [7:0] reg_isr    = 8'hfe;
   localparam logic [7:0] reg_imr    = 8'hff;

   ////////////////////////////////////////
   // Register bits
   ////////////////////////////////////////

   localparam logic [7:0] ncr_rst         = 8'h01;
   localparam logic [7:0] nsr_link        = 8'h40;
   // Wake, TX2 end and TX1 end status flags.
   localparam logic [7:0] nsr_clear_bits  = 8'h2c;
   localparam logic [7:0] rxcr_rxen       = 8'h01;
   localparam logic [7:0] rxcr_prmsc      = 8'h02;
   localparam logic [7:0] isr_pr          = 8'h01;
   localparam logic [7:0] isr_lnkchg      = 8'h20;
   localparam logic [7:0] isr_all         = 8'h3f;
   // Pointer auto-wrap, link change and receive interrupts.
   localparam logic [7:0] imr_par         = 8'h80;
   localparam logic [7:0] imr_enable_bits = 8'ha1;
   // RF, LCS, RWTO, PLE, AE, CE and FOE.
   localparam logic [7:0] rxsr_bad_mask   = 8'hbf;

   // A word read from the chip. The first word of a packet carries
   // the receive status in the high byte and the ready byte below it.
   typedef union packed {
      logic [15:0] raw;
      struct packed {
         logic [7:0] status;
         logic [7:0] ready;
      } pkt;
   } dm_word_u;

endpackage

//--- dm9000a_rx.f
dm9000a_reg_pkg.sv
enet_ctrl_pkg.sv
dm9000a_cmd_sequencer.sv
dm9000a_bus_cycle.sv
dm9000a_rx_frame.sv
dm9000a_controller.sv
dm9000a_chip_model.sv
dm9000a_controller_chk.sv
tb_dm9000a_controller.sv

//--- dm9000a_rx_frame.sv
module dm9000a_rx_frame
   import dm9000a_reg_pkg::*;
   import enet_ctrl_pkg::*;
(
   input  logic        clk_enet,
   input  logic        reset,
   input  logic        halt,
   input  logic        word_valid,
   input  word_tag_e   word_tag,
   input  dm_word_u    rd_word,
   output logic        fetch,
   output logic        pkt_done,
   output logic        rx_valid,
   output logic [15:0] rx_data
);

   logic        bad;
   logic [15:0] words_left;
   logic [15:0] words_next;
   logic [15:0] body_reads;

   // The length includes the CRC. Body reads are ceil(L/2).
   assign body_reads = {1'b0, rd_word.raw[15:1]} + 16'(rd_word.raw[0]);

   always_comb begin
      words_next = words_left;
      if (word_valid && word_tag == tag_length)
         words_next = body_reads;
      else if (word_valid && word_tag == tag_body)
         words_next = words_left - 1'b1;
   end

   // Bad frames drain regardless of halt.
   assign fetch = (words_next != 16'd0) && !(halt && !bad);

   // The last two body reads carry the CRC and are dropped.
   assign rx_valid = word_valid && !bad &&
                     (word_tag == tag_length ||
                      (word_tag == tag_body && words_left > 16'd2));
   assign rx_data  = (word_tag == tag_length) ? rd_word.raw - 16'd4 : rd_word.raw;

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         bad        <= 1'b0;
         words_left <= 16'd0;
         pkt_done   <= 1'b0;
      end else begin
         words_left <= words_next;
         pkt_done   <= word_valid && word_tag != tag_status && words_next == 16'd0;
         if (word_valid && word_tag == tag_status)
            bad <= (rd_word.pkt.status & rxsr_bad_mask) != 8'h00;
      end
   end

endmodule

//--- enet_ctrl_pkg.sv
package enet_ctrl_pkg;

   // Width of the power-up wait counter.
   localparam int spin_width = 20;

   typedef enum logic [4:0] {
      cs_phy_wait, cs_reset, cs_reset_wait, cs_init,
      cs_idle, cs_irq_read, cs_irq_clear, cs_dispatch,
      cs_link_update, cs_rx_check, cs_rx_packet, cs_rx_prefetch
   } cmd_state_e;

   typedef enum logic [3:0] {
      bs_idle, bs_index, bs_spin, bs_write, bs_rd0, bs_rd1,
      bs_pf_dummy, bs_pf_spin0, bs_pf_spin1, bs_pkt_gap
   } bus_state_e;

   typedef enum logic [1:0] {
      bus_write, bus_read, bus_prefetch, bus_packet
   } bus_kind_e;

   // Position of a captured word within a packet.
   typedef enum logic [1:0] {tag_status, tag_length, tag_body} word_tag_e;

   // Levels of the CMD pin.
   localparam logic bus_type_index = 1'b0;
   localparam logic bus_type_data  = 1'b1;

endpackage

//--- tb_dm9000a_controller.sv
module tb_dm9000a_controller
   import dm9000a_reg_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // Power-up and all packet traffic take under 2,000 cycles.
   // Halt stretches can double that, so the limit leaves a wide margin.
   localparam int          max_cycles        = 20000;
   localparam logic [47:0] mac_address       = 48'h0123_4567_89ab;
   localparam logic [63:0] multicast_address = 64'h0011_2233_4455_6677;
   localparam logic        promiscuous_en    = 1'b0;
   localparam logic        broadcast_en      = 1'b1;

   logic        clk_enet;
   logic        reset;
   logic        halt;
   logic        enet_int;
   logic        enet_rst_n;
   logic        enet_cs_n;
   logic        enet_cmd;
   logic        enet_wr_n;
   logic        enet_rd_n;
   wire  [15:0] enet_data;
   logic        link_status;
   logic        rx_valid;
   logic [15:0] rx_data;
   logic        link_up;
   logic [7:0]  irq_set;
   logic        push_valid;
   logic [15:0] push_word;
   logic        log_valid;
   logic [7:0]  log_index;
   logic [7:0]  log_value;

   logic [7:0]  pkt_bytes [0:255];
   logic [15:0] exp_writes [$];
   logic [15:0] exp_rx [$];
   logic [15:0] want;
   int          error_count;
   int          errors_at_start;
   int          tests_passed;
   int          tests_failed;
   int          halt_cycles;
   int          cycle_count;

   dm9000a_controller #(
      .mac_address       (mac_address),
      .multicast_address (multicast_address),
      .promiscuous_en    (promiscuous_en),
      .broadcast_en      (broadcast_en),
      .phy_spin_cycles   (20),
      .reset_spin_cycles (10)
   ) u_dut (
      .clk_enet    (clk_enet),
      .reset       (reset),
      .enet_int    (enet_int),
      .halt        (halt),
      .enet_rst_n  (enet_rst_n),
      .enet_cs_n   (enet_cs_n),
      .enet_cmd    (enet_cmd),
      .enet_wr_n   (enet_wr_n),
      .enet_rd_n   (enet_rd_n),
      .enet_data   (enet_data),
      .link_status (link_status),
      .rx_valid    (rx_valid),
      .rx_data     (rx_data)
   );

   dm9000a_chip_model u_chip (
      .clk_enet   (clk_enet),
      .enet_cmd   (enet_cmd),
      .enet_wr_n  (enet_wr_n),
      .enet_rd_n  (enet_rd_n),
      .enet_data  (enet_data),
      .enet_int   (enet_int),
      .link_up    (link_up),
      .irq_set    (irq_set),
      .push_valid (push_valid),
      .push_word  (push_word),
      .log_valid  (log_valid),
      .log_index  (log_index),
      .log_value  (log_value)
   );

   initial clk_enet = 1'b0;
   always #10 clk_enet = ~clk_enet;

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Power-up write n as {index, value}. PAR and MAR take the low byte first.
   function automatic logic [15:0] expected_write(input int n);
      logic [7:0] value;
      value = 8'h00;
      if (n == 0)
         return {reg_ncr, ncr_rst};
      else if (n == 1)
         return {reg_gpr, 8'h00};
      else if (n == 2)
         return {reg_nsr, nsr_clear_bits};
      else if (n == 3)
         return {reg_isr, isr_all};
      else if (n <= 9)
         return {reg_par0 + 8'(n - 4), 8'(mac_address >> (8 * (n - 4)))};
      else if (n <= 17) begin
         value = 8'(multicast_address >> (8 * (n - 10)));
         if (n == 17 && broadcast_en)
            value = value | 8'h80;
         return {reg_mar0 + 8'(n - 10), value};
      end else if (n == 18)
         return {reg_rxcr, promiscuous_en ? (rxcr_rxen | rxcr_prmsc) : rxcr_rxen};
      else
         return {reg_imr, imr_enable_bits};
   endfunction

   // Output word k of a good packet. Word 0 is the length without CRC.
   function automatic logic [15:0] expected_word(input int len, input int k);
      if (k == 0)
         return 16'(len - 4);
      return {pkt_bytes[2 * k - 1], pkt_bytes[2 * k - 2]};
   endfunction

   ////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////

   task automatic next_cycle();
      @(posedge clk_enet);
      #2;
   endtask

   // Every interrupt masks, clears ISR and unmasks once.
   task automatic raise_irq(input logic [7:0] bits);
      exp_writes.push_back({reg_imr, imr_par});
      exp_writes.push_back({reg_isr, isr_all});
      exp_writes.push_back({reg_imr, imr_enable_bits});
      irq_set = bits;
      next_cycle();
      irq_set = 8'h00;
   endtask

   task automatic queue_packet(input int len, input logic [7:0] status);
      int k;
      for (k = 0; k <= len; k++)
         pkt_bytes[k] = 8'($urandom);
      push_valid = 1'b1;
      push_word  = {status, 8'h01};
      next_cycle();
      push_word = 16'(len);
      next_cycle();
      for (k = 0; k < (len + 1) / 2; k++) begin
         push_word = {pkt_bytes[2 * k + 1], pkt_bytes[2 * k]};
         next_cycle();
      end
      push_valid = 1'b0;
      // Only frames without error flags reach the output.
      if ((status & rxsr_bad_mask) == 8'h00) begin
         for (k = 0; k <= (len - 3) / 2; k++)
            exp_rx.push_back(expected_word(len, k));
      end
   endtask

   task automatic wait_done();
      while (exp_writes.size() != 0 || exp_rx.size() != 0)
         next_cycle();
      // A few more cycles to catch stray words.
      repeat (4) next_cycle();
   endtask

   task automatic check_link(input logic expected);
      if (link_status !== expected) begin
         $display("Fail  time=%0t  link_status: got %b expected %b",
                  $time, link_status, expected);
         error_count++;
      end
   endtask

   task automatic finish_test(input string name);
      if (error_count == errors_at_start) begin
         $display("%s: passed", name);
         tests_passed++;
      end else begin
         $display("%s: failed with %0d errors", name, error_count - errors_at_start);
         tests_failed++;
      end
      errors_at_start = error_count;
   endtask

   ////////////////////////////////////////
   // Comparison of writes and output words
   ////////////////////////////////////////

   always @(posedge clk_enet) begin
      // The chip reset pin follows reset and the chip stays selected.
      if (enet_rst_n !== !reset) begin
         $display("Fail  time=%0t  enet_rst_n: got %b expected %b",
                  $time, enet_rst_n, !reset);
         error_count++;
      end
      if (enet_cs_n !== 1'b0) begin
         $display("Fail  time=%0t  enet_cs_n: got %b expected 0", $time, enet_cs_n);
         error_count++;
      end
      if (!reset) begin
         if (log_valid) begin
            if (exp_writes.size() == 0) begin
               $display("Register write %h=%h at %0t was not expected",
                        log_index, log_value, $time);
               error_count++;
            end else begin
               want = exp_writes.pop_front();
               if ({log_index, log_value} !== want) begin
                  $display("Fail  time=%0t  log_index/log_value: got %h=%h expected %h=%h",
                           $time, log_index, log_value, want[15:8], want[7:0]);
                  error_count++;
               end
            end
         end
         if (rx_valid) begin
            if (exp_rx.size() == 0) begin
               $display("rx_valid at %0t with no word expected, rx_data %h",
                        $time, rx_data);
               error_count++;
            end else begin
               want = exp_rx.pop_front();
               if (rx_data !== want) begin
                  $display("Fail  time=%0t  rx_data: got %h expected %h",
                           $time, rx_data, want);
                  error_count++;
               end
            end
         end
         // The rising cycle and two more may still finish a read.
         if (halt && rx_valid && halt_cycles > 2) begin
            $display("rx_valid at %0t after halt was high for %0d cycles",
                     $time, halt_cycles);
            error_count++;
         end
         halt_cycles = halt ? halt_cycles + 1 : 0;
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < max_cycles) begin
         @(posedge clk_enet);
         cycle_count++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      int n;
      int stretch;
      reset           = 1'b1;
      halt            = 1'b0;
      link_up         = 1'b0;
      irq_set         = 8'h00;
      push_valid      = 1'b0;
      push_word       = 16'h0000;
      error_count     = 0;
      errors_at_start = 0;
      tests_passed    = 0;
      tests_failed    = 0;
      halt_cycles     = 0;
      stretch         = 0;
      void'($urandom(66));
      for (n = 0; n < 20; n++)
         exp_writes.push_back(expected_write(n));
      repeat (5) @(posedge clk_enet);
      #2;
      reset = 1'b0;
      wait_done();
      finish_test("power-up");

      link_up = 1'b1;
      raise_irq(isr_lnkchg);
      wait_done();
      check_link(1'b1);
      link_up = 1'b0;
      raise_irq(isr_lnkchg);
      wait_done();
      check_link(1'b0);
      finish_test("link change");

      queue_packet(64, 8'h00);
      raise_irq(isr_pr);
      wait_done();
      queue_packet(65, 8'h00);
      raise_irq(isr_pr);
      wait_done();
      finish_test("good packets");

      // Middle frame carries a CRC error flag.
      queue_packet(64, 8'h00);
      queue_packet(72, 8'h02);
      queue_packet(67, 8'h00);
      raise_irq(isr_pr);
      wait_done();
      finish_test("bad and queued packets");

      queue_packet(100, 8'h00);
      raise_irq(isr_pr);
      // The length word is read without fetch. Halt covers the body.
      n = exp_rx.size();
      while (exp_rx.size() == n)
         next_cycle();
      while (exp_rx.size() != 0) begin
         if (stretch == 0) begin
            halt    = ~halt;
            stretch = 1 + $urandom % 12;
         end
         stretch--;
         next_cycle();
      end
      halt = 1'b0;
      wait_done();
      finish_test("halt");

      $display("Tests passed %0d, failed %0d, errors %0d",
               tests_passed, tests_failed, error_count);
      if (error_count == 0 && tests_failed == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule
